//--- vlog.f
verilog/cache_bus_pkg.sv
verilog/tid_ifs.sv
verilog/sync_fifo.sv
verilog/req_arbiter.sv
verilog/tid_tracker.sv
verilog/rtrn_path.sv
verilog/cache_bus_adapter.sv
sim/cache_bus_properties.sv
sim/tb_cache_bus_adapter.sv

//--- Makefile
SIM  := obj_dir/Vtb_cache_bus_adapter
SRCS := $(wildcard verilog/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) vlog.f
	verilator --binary --timing --assert -f vlog.f --top-module tb_cache_bus_adapter

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q '^\*\* PASS \*\*$$' sim.log; then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_cache_bus_adapter.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cache_bus_adapter import cache_bus_pkg::*; ();

  localparam int NUM_TXN   = 21;
  localparam int MAX_CYCLE = 40 * NUM_TXN + 100;

  logic clk_i, rst_ni;
  logic ic_req_i, ic_ack_o, ic_nc_i;
  logic [PADDR_W-1:0] ic_paddr_i, dc_paddr_i, rd_addr_o, wr_addr_o;
  logic [TID_W-1:0] ic_tid_i, dc_tid_i, ic_rtrn_tid_o, dc_rtrn_tid_o;
  logic dc_req_i, dc_ack_o, dc_store_i;
  logic [2:0] dc_size_i;
  logic [WORD_W-1:0] dc_data_i, rd_data_i, wr_data_o;
  logic ic_rtrn_vld_o, dc_rtrn_vld_o, dc_rtrn_store_o;
  logic [LINE_W-1:0] ic_rtrn_data_o, dc_rtrn_data_o;
  logic rd_req_o, rd_gnt_i, rd_id_o, rd_valid_i, rd_last_i, rd_id_i;
  logic [BLEN_W-1:0] rd_blen_o;
  logic [1:0] rd_size_o, wr_size_o;
  logic wr_req_o, wr_gnt_i, wr_valid_i, wr_rdy_o;
  logic [7:0] wr_be_o;

  // reference queues, filled on ack and drained on grant and return
  logic [31:0]  ic_gnt_addr_q[$], dc_gnt_addr_q[$], rd_addr_q[$];
  logic         ic_gnt_nc_q[$], dc_gnt_store_q[$], ic_rtn_line_q[$], dc_ld_line_q[$];
  logic [2:0]   dc_gnt_size_q[$];
  logic [63:0]  dc_gnt_data_q[$];
  logic [1:0]   ic_rtn_tid_q[$], dc_ld_tid_q[$], dc_st_tid_q[$], rd_blen_q[$];
  logic [255:0] ic_rtn_data_q[$], dc_ld_data_q[$];
  logic         rd_id_q[$];

  logic [31:0] rng_q = 32'd12;
  string test_name = "reset";
  int cycles = 0, wr_pend = 0, beat_k = 0, rsp_wait = 0, wr_wait = 0;
  int rd_gnt_wait = 0, wr_gnt_wait = 0, last_path = 2;
  // write responses held by the adapter and not yet acked
  int wr_rsp_cnt = 0;
  bit beat_on = 0, other_waiting = 0, alt_check = 0;
  logic [1:0] ic_tid_n = '0, dc_tid_n = '0;

  cache_bus_adapter u_dut (.*);

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic expect_eq(input string what, input logic [255:0] exp, input logic [255:0] act);
    assert (exp === act) else begin
      $display("ERR %s: %s expected %h actual %h", test_name, what, exp, act);
      stop_with_failure("reference check failed");
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int next_delay();
    rng_q = xorshift32(rng_q);
    return int'(rng_q % 32'd4);
  endfunction

  // memory rule: word k carries the byte address of that word in both halves
  function automatic logic [63:0] mem_word(input logic [31:0] addr, input int k);
    logic [31:0] a;
    a = addr + 32'(k * 8);
    return {a, a};
  endfunction

  function automatic logic [255:0] mem_line(input logic [31:0] addr);
    logic [255:0] l;
    for (int k = 0; k < 4; k++) begin
      l[k*64 +: 64] = mem_word(addr, k);
    end
    return l;
  endfunction

  function automatic logic [7:0] exp_be(input logic [2:0] off, input logic [1:0] size);
    int n;
    logic [7:0] be;
    n = 1 << size;
    be = '0;
    for (int i = 0; i < 8; i++) begin
      if (i >= int'(off) && i < int'(off) + n) be[i] = 1'b1;
    end
    return be;
  endfunction

  // round-robin must hand the bus to the other path when it was waiting
  task automatic note_grant(input int p);
    if (alt_check && last_path == p && other_waiting) begin
      expect_eq("granted path", 256'(1 - p), 256'(p));
    end
    last_path = p;
    other_waiting = (p == 1) ? (ic_gnt_addr_q.size() != 0) : (dc_gnt_addr_q.size() != 0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitor and bus model
  //////////////////////////////////////////////////////////////////////

  task automatic sample_cycle();
    logic [255:0] exp_line;
    if (rd_req_o && rd_gnt_i) begin
      rd_addr_q.push_back(rd_addr_o);
      rd_blen_q.push_back(rd_blen_o);
      rd_id_q.push_back(rd_id_o);
      if (rd_id_o == BUS_ID_IC) begin
        if (ic_gnt_addr_q.size() == 0) stop_with_failure("read granted with no fill pending");
        note_grant(0);
        expect_eq("fill addr", 256'(ic_gnt_addr_q[0]), 256'(rd_addr_o));
        expect_eq("fill blen", ic_gnt_nc_q[0] ? 256'(0) : 256'(3), 256'(rd_blen_o));
        void'(ic_gnt_addr_q.pop_front());
        void'(ic_gnt_nc_q.pop_front());
      end else begin
        if (dc_gnt_addr_q.size() == 0) stop_with_failure("read granted with no load pending");
        note_grant(1);
        expect_eq("load channel", 256'(0), 256'(dc_gnt_store_q[0]));
        expect_eq("load addr", 256'(dc_gnt_addr_q[0]), 256'(rd_addr_o));
        expect_eq("load blen", dc_gnt_size_q[0][2] ? 256'(3) : 256'(0), 256'(rd_blen_o));
        expect_eq("load size", 256'(dc_gnt_size_q[0][1:0]), 256'(rd_size_o));
        void'(dc_gnt_addr_q.pop_front());
        void'(dc_gnt_store_q.pop_front());
        void'(dc_gnt_size_q.pop_front());
        void'(dc_gnt_data_q.pop_front());
      end
    end
    if (wr_req_o && wr_gnt_i) begin
      wr_pend++;
      if (dc_gnt_addr_q.size() == 0) stop_with_failure("write granted with no store pending");
      note_grant(1);
      expect_eq("store channel", 256'(1), 256'(dc_gnt_store_q[0]));
      expect_eq("store addr", 256'(dc_gnt_addr_q[0]), 256'(wr_addr_o));
      expect_eq("store be", 256'(exp_be(dc_gnt_addr_q[0][2:0], dc_gnt_size_q[0][1:0])),
                256'(wr_be_o));
      expect_eq("store size", 256'(dc_gnt_size_q[0][1:0]), 256'(wr_size_o));
      expect_eq("store data", 256'(dc_gnt_data_q[0]), 256'(wr_data_o));
      void'(dc_gnt_addr_q.pop_front());
      void'(dc_gnt_store_q.pop_front());
      void'(dc_gnt_size_q.pop_front());
      void'(dc_gnt_data_q.pop_front());
    end
    if (ic_req_i && ic_ack_o) begin
      ic_gnt_addr_q.push_back(ic_paddr_i);
      ic_gnt_nc_q.push_back(ic_nc_i);
      ic_rtn_tid_q.push_back(ic_tid_i);
      ic_rtn_data_q.push_back(mem_line(ic_paddr_i));
      ic_rtn_line_q.push_back(!ic_nc_i);
    end
    if (dc_req_i && dc_ack_o) begin
      dc_gnt_addr_q.push_back(dc_paddr_i);
      dc_gnt_store_q.push_back(dc_store_i);
      dc_gnt_size_q.push_back(dc_size_i);
      dc_gnt_data_q.push_back(dc_data_i);
      if (dc_store_i) begin
        dc_st_tid_q.push_back(dc_tid_i);
      end else begin
        dc_ld_tid_q.push_back(dc_tid_i);
        dc_ld_data_q.push_back(mem_line(dc_paddr_i));
        dc_ld_line_q.push_back(dc_size_i[2]);
      end
    end
    if (ic_rtrn_vld_o) begin
      if (ic_rtn_tid_q.size() == 0) stop_with_failure("instruction return with nothing pending");
      expect_eq("fill tid", 256'(ic_rtn_tid_q.pop_front()), 256'(ic_rtrn_tid_o));
      exp_line = ic_rtn_data_q.pop_front();
      if (ic_rtn_line_q.pop_front()) begin
        expect_eq("fill line", exp_line, ic_rtrn_data_o);
      end else begin
        expect_eq("fill word 0", 256'(exp_line[63:0]), 256'(ic_rtrn_data_o[63:0]));
      end
    end
    if (dc_rtrn_vld_o && dc_rtrn_store_o) begin
      if (dc_st_tid_q.size() == 0) stop_with_failure("store ack with no store pending");
      wr_rsp_cnt--;
      expect_eq("store ack tid", 256'(dc_st_tid_q.pop_front()), 256'(dc_rtrn_tid_o));
    end else if (dc_rtrn_vld_o) begin
      if (dc_ld_tid_q.size() == 0) stop_with_failure("load return with nothing pending");
      expect_eq("load tid", 256'(dc_ld_tid_q.pop_front()), 256'(dc_rtrn_tid_o));
      exp_line = dc_ld_data_q.pop_front();
      if (dc_ld_line_q.pop_front()) begin
        expect_eq("load line", exp_line, dc_rtrn_data_o);
      end else begin
        expect_eq("load word 0", 256'(exp_line[63:0]), 256'(dc_rtrn_data_o[63:0]));
      end
    end
    // ready while fewer than META_DEPTH responses wait for their ack
    expect_eq("wr ready", 256'(wr_rsp_cnt < int'(META_DEPTH)), 256'(wr_rdy_o));
    if (wr_valid_i) begin
      wr_rsp_cnt++;
    end
  endtask

  task automatic drive_bus();
    rd_gnt_i = 1'b0;
    wr_gnt_i = 1'b0;
    if (rd_req_o) begin
      if (rd_gnt_wait == 0) begin
        rd_gnt_i = 1'b1;
        rd_gnt_wait = next_delay();
      end else rd_gnt_wait--;
    end
    if (wr_req_o) begin
      if (wr_gnt_wait == 0) begin
        wr_gnt_i = 1'b1;
        wr_gnt_wait = next_delay();
      end else wr_gnt_wait--;
    end
    // read beats, one transaction at a time in grant order
    rd_valid_i = 1'b0;
    rd_last_i = 1'b0;
    if (!beat_on && rd_addr_q.size() != 0) begin
      if (rsp_wait == 0) begin
        beat_on = 1'b1;
        beat_k = 0;
      end else rsp_wait--;
    end
    if (beat_on) begin
      rd_valid_i = 1'b1;
      rd_id_i = rd_id_q[0];
      rd_data_i = mem_word(rd_addr_q[0], beat_k);
      rd_last_i = (beat_k == int'(rd_blen_q[0]));
      beat_k++;
      if (rd_last_i) begin
        void'(rd_addr_q.pop_front());
        void'(rd_blen_q.pop_front());
        void'(rd_id_q.pop_front());
        beat_on = 1'b0;
        rsp_wait = next_delay();
      end
    end
    // write responses only while the adapter can count them
    wr_valid_i = 1'b0;
    if (wr_pend > 0 && wr_rdy_o) begin
      if (wr_wait == 0) begin
        wr_valid_i = 1'b1;
        wr_pend--;
        wr_wait = next_delay();
      end else wr_wait--;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // cache side stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic send_fill(input logic [31:0] addr, input logic nc);
    @(posedge clk_i);
    #1;
    ic_req_i = 1'b1;
    ic_paddr_i = addr;
    ic_nc_i = nc;
    ic_tid_i = ic_tid_n;
    ic_tid_n++;
    do @(negedge clk_i); while (!ic_ack_o);
  endtask

  task automatic send_dc(input logic st, input logic [31:0] addr, input logic [2:0] size,
                         input logic [63:0] data);
    @(posedge clk_i);
    #1;
    dc_req_i = 1'b1;
    dc_store_i = st;
    dc_paddr_i = addr;
    dc_size_i = size;
    dc_data_i = data;
    dc_tid_i = dc_tid_n;
    dc_tid_n++;
    do @(negedge clk_i); while (!dc_ack_o);
  endtask

  task automatic release_req(input bit drop_ic, input bit drop_dc);
    @(posedge clk_i);
    #1;
    if (drop_ic) ic_req_i = 1'b0;
    if (drop_dc) dc_req_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (ic_rtn_tid_q.size() + dc_ld_tid_q.size() + dc_st_tid_q.size() != 0 ||
           rd_addr_q.size() != 0 || wr_pend != 0) begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
  endtask

  // instruction fills are always full doubleword reads
  fill_size: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_req_o && rd_id_o == BUS_ID_IC) |-> rd_size_o == SIZE_DWORD)
    else begin
      $display("ERR %s: fill size expected %0d actual %0d", test_name, SIZE_DWORD, rd_size_o);
      stop_with_failure("reference check failed");
    end

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles > MAX_CYCLE) stop_with_failure("timeout: transactions did not complete");
    end
  end

  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni) sample_cycle();
      @(posedge clk_i);
      #1;
      drive_bus();
    end
  end

  initial begin
    logic [2:0]  off;
    logic [1:0]  sz;
    rst_ni = 1'b0;
    {ic_req_i, ic_nc_i, dc_req_i, dc_store_i} = '0;
    {rd_gnt_i, wr_gnt_i, rd_valid_i, rd_last_i, rd_id_i, wr_valid_i} = '0;
    ic_paddr_i = '0;
    ic_tid_i = '0;
    dc_paddr_i = '0;
    dc_size_i = '0;
    dc_data_i = '0;
    dc_tid_i = '0;
    rd_data_i = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_name = "line_fill";
    send_fill(32'h0000_1000, 1'b0);
    send_fill(32'h0000_2040, 1'b0);
    release_req(1'b1, 1'b1);
    wait_idle();

    test_name = "single_word";
    send_fill(32'h0000_3008, 1'b1);
    release_req(1'b1, 1'b0);
    send_dc(1'b0, 32'h0000_4010, 3'b011, '0);
    send_dc(1'b0, 32'h0000_4128, 3'b010, '0);
    release_req(1'b0, 1'b1);
    wait_idle();

    test_name = "line_load";
    send_dc(1'b0, 32'h0000_5000, 3'b111, '0);
    send_dc(1'b0, 32'h0000_5020, 3'b111, '0);
    release_req(1'b1, 1'b1);
    wait_idle();

    test_name = "stores";
    for (int i = 0; i < 8; i++) begin
      sz = 2'(i % 4);
      rng_q = xorshift32(rng_q);
      off = rng_q[2:0] & ~3'((1 << sz) - 1);
      rng_q = xorshift32(rng_q);
      send_dc(1'b1, 32'h0000_6000 + 32'(i * 8) + 32'(off), {1'b0, sz}, {rng_q, ~rng_q});
    end
    release_req(1'b1, 1'b1);
    wait_idle();

    test_name = "round_robin";
    alt_check = 1'b1;
    last_path = 2;
    fork
      begin
        for (int i = 0; i < 3; i++) send_fill(32'h0000_7000 + 32'(i * 32), 1'b0);
        release_req(1'b1, 1'b0);
      end
      begin
        for (int i = 0; i < 3; i++) send_dc(1'b0, 32'h0000_8000 + 32'(i * 32), 3'b111, '0);
        release_req(1'b0, 1'b1);
      end
    join
    wait_idle();

    if (ic_gnt_addr_q.size() + dc_gnt_addr_q.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_with_failure("requests were accepted but never granted");
    end
  end

endmodule

`default_nettype wire

//--- sim/cache_bus_properties.sv
`timescale 1ns/1ns
`default_nettype none

module cache_bus_properties import cache_bus_pkg::*; (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               rd_req_o,
  input logic               rd_gnt_i,
  input logic [PADDR_W-1:0] rd_addr_o,
  input logic [BLEN_W-1:0]  rd_blen_o,
  input logic [1:0]         rd_size_o,
  input logic               rd_id_o,
  input logic               wr_req_o,
  input logic               wr_gnt_i,
  input logic [PADDR_W-1:0] wr_addr_o,
  input logic [WORD_W-1:0]  wr_data_o,
  input logic [7:0]         wr_be_o,
  input logic [1:0]         wr_size_o,
  input logic               ic_rtrn_vld_o,
  input logic               dc_rtrn_vld_o
);

  // a read request stays put until the bus grants it
  rd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_req_o && !rd_gnt_i) |=> (rd_req_o && $stable({rd_addr_o, rd_blen_o, rd_size_o, rd_id_o})))
    else $error("read request changed before its grant");

  wr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_req_o && !wr_gnt_i) |=> (wr_req_o && $stable({wr_addr_o, wr_data_o, wr_be_o, wr_size_o})))
    else $error("write request changed before its grant");

  // only one channel is driven at a time
  one_channel: assert property (@(posedge clk_i) disable iff (!rst_ni) !(rd_req_o && wr_req_o))
    else $error("read and write requests raised together");

  quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !(ic_rtrn_vld_o || dc_rtrn_vld_o))
    else $error("return valid raised during reset");

endmodule

bind cache_bus_adapter cache_bus_properties u_props (.*);

`default_nettype wire

//--- verilog/cache_bus_adapter.sv
`timescale 1ns/1ns
`default_nettype none

module cache_bus_adapter import cache_bus_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // instruction cache requests
  input  logic               ic_req_i,
  output logic               ic_ack_o,
  input  logic [PADDR_W-1:0] ic_paddr_i,
  input  logic               ic_nc_i,
  input  logic [TID_W-1:0]   ic_tid_i,
  // data cache requests
  input  logic               dc_req_i,
  output logic               dc_ack_o,
  input  logic               dc_store_i,
  input  logic [PADDR_W-1:0] dc_paddr_i,
  input  logic [2:0]         dc_size_i,
  input  logic [WORD_W-1:0]  dc_data_i,
  input  logic [TID_W-1:0]   dc_tid_i,
  // returns must be taken in the cycle they are valid
  output logic               ic_rtrn_vld_o,
  output logic [TID_W-1:0]   ic_rtrn_tid_o,
  output logic [LINE_W-1:0]  ic_rtrn_data_o,
  output logic               dc_rtrn_vld_o,
  output logic               dc_rtrn_store_o,
  output logic [TID_W-1:0]   dc_rtrn_tid_o,
  output logic [LINE_W-1:0]  dc_rtrn_data_o,
  // bus read channel
  output logic               rd_req_o,
  input  logic               rd_gnt_i,
  output logic [PADDR_W-1:0] rd_addr_o,
  output logic [BLEN_W-1:0]  rd_blen_o,
  output logic [1:0]         rd_size_o,
  output logic               rd_id_o,
  input  logic               rd_valid_i,
  input  logic               rd_last_i,
  input  logic               rd_id_i,
  input  logic [WORD_W-1:0]  rd_data_i,
  // bus write channel
  output logic               wr_req_o,
  input  logic               wr_gnt_i,
  output logic [PADDR_W-1:0] wr_addr_o,
  output logic [WORD_W-1:0]  wr_data_o,
  output logic [7:0]         wr_be_o,
  output logic [1:0]         wr_size_o,
  input  logic               wr_valid_i,
  output logic               wr_rdy_o
);

  tid_push_if u_push ();
  tid_pop_if  u_pop ();

  req_arbiter u_arb (
    .clk_i, .rst_ni,
    .ic_req_i, .ic_ack_o, .ic_paddr_i, .ic_nc_i, .ic_tid_i,
    .dc_req_i, .dc_ack_o, .dc_store_i, .dc_paddr_i, .dc_size_i, .dc_data_i, .dc_tid_i,
    .rd_req_o, .rd_gnt_i, .rd_addr_o, .rd_blen_o, .rd_size_o, .rd_id_o,
    .wr_req_o, .wr_gnt_i, .wr_addr_o, .wr_data_o, .wr_be_o, .wr_size_o,
    .push (u_push)
  );

  tid_tracker u_trk (
    .clk_i, .rst_ni,
    .push (u_push),
    .pop  (u_pop)
  );

  rtrn_path u_rtrn (
    .clk_i, .rst_ni,
    .rd_valid_i, .rd_last_i, .rd_id_i, .rd_data_i,
    .wr_valid_i, .wr_rdy_o,
    .ic_rtrn_vld_o, .ic_rtrn_tid_o, .ic_rtrn_data_o,
    .dc_rtrn_vld_o, .dc_rtrn_store_o, .dc_rtrn_tid_o, .dc_rtrn_data_o,
    .pop (u_pop)
  );

endmodule

`default_nettype wire

//--- verilog/rtrn_path.sv
`timescale 1ns/1ns
`default_nettype none

module rtrn_path import cache_bus_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  // bus read beats
  input  logic              rd_valid_i,
  input  logic              rd_last_i,
  input  logic              rd_id_i,
  input  logic [WORD_W-1:0] rd_data_i,
  // bus write responses
  input  logic              wr_valid_i,
  output logic              wr_rdy_o,
  // instruction cache returns
  output logic              ic_rtrn_vld_o,
  output logic [TID_W-1:0]  ic_rtrn_tid_o,
  output logic [LINE_W-1:0] ic_rtrn_data_o,
  // data cache returns
  output logic              dc_rtrn_vld_o,
  output logic              dc_rtrn_store_o,
  output logic [TID_W-1:0]  dc_rtrn_tid_o,
  output logic [LINE_W-1:0] dc_rtrn_data_o,
  tid_pop_if.rtrn           pop
);

  logic [$clog2(META_DEPTH+1)-1:0]   pend_q, pend_d;
  logic                              pend_pop;
  logic                              ic_rd_en, dc_rd_en;
  logic                              ic_vld_d, ic_vld_q, dc_vld_d, dc_vld_q;
  logic                              dc_store_d, dc_store_q;
  logic [TID_W-1:0]                  ic_tid_q, dc_tid_d, dc_tid_q;
  logic                              ic_first_q, dc_first_q;
  logic [LINE_WORDS-1:0][WORD_W-1:0] ic_shift_d, ic_shift_q;
  logic [LINE_WORDS-1:0][WORD_W-1:0] dc_shift_d, dc_shift_q;

  //////////////////////////////////////////////////////////////////////
  // return decode
  //////////////////////////////////////////////////////////////////////

  // write responses are only counted, the ids live in the tracker
  assign wr_rdy_o = (pend_q < ($clog2(META_DEPTH+1))'(META_DEPTH));

  // instruction channel decodes on its own
  assign ic_rd_en   = rd_valid_i & (rd_id_i == BUS_ID_IC);
  assign ic_vld_d   = ic_rd_en & rd_last_i;
  assign pop.ic_pop = ic_vld_d;

  always_comb begin
    dc_rd_en      = 1'b0;
    dc_vld_d      = 1'b0;
    dc_store_d    = 1'b0;
    dc_tid_d      = pop.dc_rd_tid;
    pend_pop      = 1'b0;
    pop.dc_rd_pop = 1'b0;
    pop.dc_wr_pop = 1'b0;
    // read beats win over store acks
    if (rd_valid_i && rd_id_i == BUS_ID_DC) begin
      dc_rd_en      = 1'b1;
      dc_vld_d      = rd_last_i;
      pop.dc_rd_pop = rd_last_i;
    end else if (pend_q != '0) begin
      pend_pop      = 1'b1;
      dc_vld_d      = 1'b1;
      dc_store_d    = 1'b1;
      dc_tid_d      = pop.dc_wr_tid;
      pop.dc_wr_pop = 1'b1;
    end
  end

  always_comb begin
    pend_d = pend_q;
    if (wr_valid_i && wr_rdy_o) begin
      pend_d = pend_d + 1'b1;
    end
    if (pend_pop) begin
      pend_d = pend_d - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // line assembly
  //////////////////////////////////////////////////////////////////////

  // beats enter from the top, the first beat also lands in word 0
  always_comb begin
    ic_shift_d = ic_shift_q;
    dc_shift_d = dc_shift_q;
    if (ic_rd_en) begin
      ic_shift_d = {rd_data_i, ic_shift_q[LINE_WORDS-1:1]};
      if (ic_first_q) begin
        ic_shift_d[0] = rd_data_i;
      end
    end
    if (dc_rd_en) begin
      dc_shift_d = {rd_data_i, dc_shift_q[LINE_WORDS-1:1]};
      if (dc_first_q) begin
        dc_shift_d[0] = rd_data_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q     <= '0;
      ic_first_q <= 1'b1;
      dc_first_q <= 1'b1;
      ic_vld_q   <= 1'b0;
      dc_vld_q   <= 1'b0;
      dc_store_q <= 1'b0;
    end else begin
      pend_q   <= pend_d;
      ic_vld_q <= ic_vld_d;
      dc_vld_q <= dc_vld_d;
      // next beat after a last is the first of a new transfer
      if (ic_rd_en) begin
        ic_first_q <= rd_last_i;
      end
      if (dc_rd_en) begin
        dc_first_q <= rd_last_i;
      end
      if (dc_vld_d) begin
        dc_store_q <= dc_store_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    ic_shift_q <= ic_shift_d;
    dc_shift_q <= dc_shift_d;
    if (ic_vld_d) begin
      ic_tid_q <= pop.ic_tid;
    end
    if (dc_vld_d) begin
      dc_tid_q <= dc_tid_d;
    end
  end

  // returns straight from registers
  assign ic_rtrn_vld_o   = ic_vld_q;
  assign ic_rtrn_tid_o   = ic_tid_q;
  assign ic_rtrn_data_o  = ic_shift_q;
  assign dc_rtrn_vld_o   = dc_vld_q;
  assign dc_rtrn_store_o = dc_store_q;
  assign dc_rtrn_tid_o   = dc_tid_q;
  assign dc_rtrn_data_o  = dc_shift_q;

endmodule

`default_nettype wire

//--- verilog/tid_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module tid_tracker import cache_bus_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  tid_push_if.trk push,
  tid_pop_if.trk  pop
);

  // outstanding instruction fills
  sync_fifo #(.Width(TID_W), .Depth(META_DEPTH)) u_ic_rd_ids (
    .clk_i, .rst_ni,
    .push_i  (push.ic_push),
    .pop_i   (pop.ic_pop),
    .data_i  (push.tid),
    .data_o  (pop.ic_tid),
    .full_o  (push.ic_full),
    .empty_o ()
  );

  // outstanding data loads
  sync_fifo #(.Width(TID_W), .Depth(META_DEPTH)) u_dc_rd_ids (
    .clk_i, .rst_ni,
    .push_i  (push.dc_rd_push),
    .pop_i   (pop.dc_rd_pop),
    .data_i  (push.tid),
    .data_o  (pop.dc_rd_tid),
    .full_o  (push.dc_rd_full),
    .empty_o ()
  );

  // outstanding data stores
  sync_fifo #(.Width(TID_W), .Depth(META_DEPTH)) u_dc_wr_ids (
    .clk_i, .rst_ni,
    .push_i  (push.dc_wr_push),
    .pop_i   (pop.dc_wr_pop),
    .data_i  (push.tid),
    .data_o  (pop.dc_wr_tid),
    .full_o  (push.dc_wr_full),
    .empty_o ()
  );

endmodule

`default_nettype wire

//--- verilog/req_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module req_arbiter import cache_bus_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // instruction cache
  input  logic               ic_req_i,
  output logic               ic_ack_o,
  input  logic [PADDR_W-1:0] ic_paddr_i,
  input  logic               ic_nc_i,
  input  logic [TID_W-1:0]   ic_tid_i,
  // data cache
  input  logic               dc_req_i,
  output logic               dc_ack_o,
  input  logic               dc_store_i,
  input  logic [PADDR_W-1:0] dc_paddr_i,
  input  logic [2:0]         dc_size_i,
  input  logic [WORD_W-1:0]  dc_data_i,
  input  logic [TID_W-1:0]   dc_tid_i,
  // bus read request
  output logic               rd_req_o,
  input  logic               rd_gnt_i,
  output logic [PADDR_W-1:0] rd_addr_o,
  output logic [BLEN_W-1:0]  rd_blen_o,
  output logic [1:0]         rd_size_o,
  output logic               rd_id_o,
  // bus write request
  output logic               wr_req_o,
  input  logic               wr_gnt_i,
  output logic [PADDR_W-1:0] wr_addr_o,
  output logic [WORD_W-1:0]  wr_data_o,
  output logic [7:0]         wr_be_o,
  output logic [1:0]         wr_size_o,
  tid_push_if.arb            push
);

  logic                            ic_full, ic_empty, dc_full, dc_empty;
  logic [PADDR_W+TID_W:0]          ic_head;
  logic [PADDR_W+WORD_W+TID_W+3:0] dc_head;
  logic [PADDR_W-1:0]              ic_paddr, dc_paddr;
  logic                            ic_nc, dc_store;
  logic [TID_W-1:0]                ic_tid, dc_tid;
  logic [2:0]                      dc_size;
  logic [WORD_W-1:0]               dc_data;
  logic                            ic_elig, dc_elig, arb_vld, sel, gnt;
  logic                            ic_pop, dc_pop;
  logic                            lock_q, sel_q, rr_q;

  //////////////////////////////////////////////////////////////////////
  // request queues
  //////////////////////////////////////////////////////////////////////

  assign ic_ack_o = ic_req_i & ~ic_full;
  assign dc_ack_o = dc_req_i & ~dc_full;

  sync_fifo #(.Width(PADDR_W + 1 + TID_W), .Depth(REQ_DEPTH)) u_ic_queue (
    .clk_i, .rst_ni,
    .push_i  (ic_ack_o),
    .pop_i   (ic_pop),
    .data_i  ({ic_paddr_i, ic_nc_i, ic_tid_i}),
    .data_o  (ic_head),
    .full_o  (ic_full),
    .empty_o (ic_empty)
  );

  sync_fifo #(.Width(PADDR_W + WORD_W + TID_W + 4), .Depth(REQ_DEPTH)) u_dc_queue (
    .clk_i, .rst_ni,
    .push_i  (dc_ack_o),
    .pop_i   (dc_pop),
    .data_i  ({dc_store_i, dc_paddr_i, dc_size_i, dc_data_i, dc_tid_i}),
    .data_o  (dc_head),
    .full_o  (dc_full),
    .empty_o (dc_empty)
  );

  assign {ic_paddr, ic_nc, ic_tid}                    = ic_head;
  assign {dc_store, dc_paddr, dc_size, dc_data, dc_tid} = dc_head;

  //////////////////////////////////////////////////////////////////////
  // round-robin with hold until grant
  //////////////////////////////////////////////////////////////////////

  // a path needs room in the id fifo of the channel it will use
  assign ic_elig = ~ic_empty & ~push.ic_full;
  assign dc_elig = ~dc_empty & (dc_store ? ~push.dc_wr_full : ~push.dc_rd_full);
  assign arb_vld = lock_q | ic_elig | dc_elig;

  always_comb begin
    if (lock_q) begin
      sel = sel_q;
    end else if (ic_elig && dc_elig) begin
      sel = rr_q;
    end else begin
      sel = dc_elig;
    end
  end

  assign gnt    = (rd_req_o & rd_gnt_i) | (wr_req_o & wr_gnt_i);
  assign ic_pop = gnt & (sel == BUS_ID_IC);
  assign dc_pop = gnt & (sel == BUS_ID_DC);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
      sel_q  <= BUS_ID_IC;
      rr_q   <= BUS_ID_IC;
    end else begin
      lock_q <= arb_vld & ~gnt;
      sel_q  <= sel;
      if (gnt) begin
        rr_q <= ~sel;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus request formation
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_req_o  = 1'b0;
    wr_req_o  = 1'b0;
    rd_addr_o = ic_paddr;
    rd_size_o = SIZE_DWORD;
    rd_id_o   = BUS_ID_IC;
    rd_blen_o = '0;
    if (sel == BUS_ID_DC) begin
      rd_addr_o = dc_paddr;
      rd_size_o = dc_size[1:0];
      rd_id_o   = BUS_ID_DC;
      // size bit 2 marks a full line load
      if (dc_size[2]) begin
        rd_blen_o = BLEN_W'(LINE_WORDS - 1);
      end
      rd_req_o = arb_vld & ~dc_store;
      wr_req_o = arb_vld & dc_store;
    end else begin
      if (!ic_nc) begin
        rd_blen_o = BLEN_W'(LINE_WORDS - 1);
      end
      rd_req_o = arb_vld;
    end
  end

  // stores are always single word
  assign wr_addr_o = dc_paddr;
  assign wr_data_o = dc_data;
  assign wr_size_o = dc_size[1:0];
  assign wr_be_o   = to_byte_enable(dc_paddr[2:0], dc_size[1:0]);

  // remember the requester id in the grant cycle
  assign push.ic_push    = rd_req_o & rd_gnt_i & (sel == BUS_ID_IC);
  assign push.dc_rd_push = rd_req_o & rd_gnt_i & (sel == BUS_ID_DC);
  assign push.dc_wr_push = wr_req_o & wr_gnt_i;
  assign push.tid        = (sel == BUS_ID_DC) ? dc_tid : ic_tid;

endmodule

`default_nettype wire

//--- verilog/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  logic [Width-1:0]             mem_q [Depth];
  logic [$clog2(Depth)-1:0]     wr_ptr_q, rd_ptr_q;
  logic [$clog2(Depth+1)-1:0]   cnt_q;
  logic                         do_push, do_pop;

  assign full_o  = (cnt_q == ($clog2(Depth+1))'(Depth));
  assign empty_o = (cnt_q == '0);

  // overflow and underflow requests are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // head word is always visible
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ($clog2(Depth))'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ($clog2(Depth))'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/tid_ifs.sv
`timescale 1ns/1ns
`default_nettype none

// id pushes from the arbiter, full flags back from the tracker
interface tid_push_if import cache_bus_pkg::*; ();
  logic             ic_push;
  logic             dc_rd_push;
  logic             dc_wr_push;
  logic [TID_W-1:0] tid;
  logic             ic_full;
  logic             dc_rd_full;
  logic             dc_wr_full;

  modport arb (
    output ic_push, dc_rd_push, dc_wr_push, tid,
    input  ic_full, dc_rd_full, dc_wr_full
  );

  modport trk (
    input  ic_push, dc_rd_push, dc_wr_push, tid,
    output ic_full, dc_rd_full, dc_wr_full
  );
endinterface

// id pops from the return path, fifo heads back from the tracker
interface tid_pop_if import cache_bus_pkg::*; ();
  logic             ic_pop;
  logic             dc_rd_pop;
  logic             dc_wr_pop;
  logic [TID_W-1:0] ic_tid;
  logic [TID_W-1:0] dc_rd_tid;
  logic [TID_W-1:0] dc_wr_tid;

  modport rtrn (
    output ic_pop, dc_rd_pop, dc_wr_pop,
    input  ic_tid, dc_rd_tid, dc_wr_tid
  );

  modport trk (
    input  ic_pop, dc_rd_pop, dc_wr_pop,
    output ic_tid, dc_rd_tid, dc_wr_tid
  );
endinterface

`default_nettype wire

//--- verilog/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus and line geometry
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned WORD_W     = 64;
  localparam int unsigned PADDR_W    = 32;
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned LINE_W     = LINE_WORDS * WORD_W;
  // burst length field holds beats minus one
  localparam int unsigned BLEN_W     = $clog2(LINE_WORDS);

  // cache side transaction ids
  localparam int unsigned TID_W      = 2;

  // queue depths
  localparam int unsigned REQ_DEPTH  = 2;
  localparam int unsigned META_DEPTH = 4;

  // bus id marks which cache a read belongs to
  localparam logic BUS_ID_IC = 1'b0;
  localparam logic BUS_ID_DC = 1'b1;

  // 8 byte transfers, used for every instruction fill
  localparam logic [1:0] SIZE_DWORD = 2'd3;

  // aligned byte enables within one 64 bit word
  function automatic logic [7:0] to_byte_enable(input logic [2:0] off,
                                                input logic [1:0] size);
    logic [7:0] be;
    case (size)
      2'b00:   be = 8'h01 << off;
      2'b01:   be = 8'h03 << {off[2:1], 1'b0};
      2'b10:   be = 8'h0f << {off[2], 2'b00};
      default: be = 8'hff;
    endcase
    return be;
  endfunction

endpackage

`default_nettype wire
